//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // access size, low two bits of the control sideband
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_t;

    // bit 2 unsigned flag, bits 1..0 size
    localparam int CTRL_W     = 3;

    // line geometry shared by cache and store
    localparam int LINE_BYTES = 16;
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int OFFS_W     = 4;
    localparam int WORD_W     = 32;

    typedef enum logic [1:0] {
        C_IDLE,
        C_LOOKUP,
        C_REFILL,
        C_WRITE
    } cache_state_t;

endpackage

`default_nettype wire

//--- verilog/line_store.sv
`default_nettype none

module line_store #(
    parameter int ADDR_W        = 16,
    parameter int STORE_LINES   = 64,
    parameter int STORE_LATENCY = 4
) (
    input  wire                                  CLK,
    input  wire                                  i_rrst_x,
    input  wire                                  i_st_req,
    input  wire                                  i_st_we,
    input  wire  [ADDR_W-mem_pkg::OFFS_W-1:0]    i_st_line,
    input  wire  [mem_pkg::LINE_W-1:0]           i_st_wdata,
    input  wire  [mem_pkg::LINE_BYTES-1:0]       i_st_mask,
    output logic                                 o_st_ack,
    output logic [mem_pkg::LINE_W-1:0]           o_st_rdata
);
    localparam int SL_W  = $clog2(STORE_LINES);
    localparam int CNT_W = $clog2(STORE_LATENCY + 1);

    logic [mem_pkg::LINE_W-1:0]  mem [STORE_LINES];
    logic [CNT_W-1:0]            r_cnt;

    // line addresses above the store size wrap around
    wire [SL_W-1:0] w_idx  = i_st_line[SL_W-1:0];
    // last waiting cycle, ack follows on the next one
    wire            w_fire = i_st_req && !o_st_ack && (r_cnt == CNT_W'(STORE_LATENCY - 1));

    initial begin
        for (int i = 0; i < STORE_LINES; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_cnt    <= '0;
            o_st_ack <= 1'b0;
        end else begin
            o_st_ack <= w_fire;
            if (o_st_ack) begin
                r_cnt <= '0;
            end else if (i_st_req) begin
                r_cnt <= r_cnt + 1'b1;
            end
        end
    end

    // byte-column write and line read on the same edge
    always @(posedge CLK) begin
        if (w_fire) begin
            for (int b = 0; b < mem_pkg::LINE_BYTES; b++) begin
                if (i_st_we && i_st_mask[b]) begin
                    mem[w_idx][b*8 +: 8] <= i_st_wdata[b*8 +: 8];
                end
            end
            o_st_rdata <= mem[w_idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/line_cache.sv
`default_nettype none

module line_cache #(
    parameter int ADDR_W      = 16,
    parameter int CACHE_LINES = 8
) (
    input  wire                                  CLK,
    input  wire                                  i_rrst_x,
    input  wire                                  i_req,
    input  wire                                  i_we,
    input  wire  [ADDR_W-mem_pkg::OFFS_W-1:0]    i_addr,
    input  wire  [mem_pkg::LINE_W-1:0]           i_wline,
    input  wire  [mem_pkg::LINE_BYTES-1:0]       i_wmask,
    input  wire                                  i_st_ack,
    input  wire  [mem_pkg::LINE_W-1:0]           i_st_rdata,
    output wire                                  o_done,
    output wire  [mem_pkg::LINE_W-1:0]           o_rline,
    output wire                                  o_st_req,
    output wire                                  o_st_we,
    output wire  [ADDR_W-mem_pkg::OFFS_W-1:0]    o_st_line,
    output wire  [mem_pkg::LINE_W-1:0]           o_st_wdata,
    output wire  [mem_pkg::LINE_BYTES-1:0]       o_st_mask
);
    localparam int LA_W  = ADDR_W - mem_pkg::OFFS_W;
    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = LA_W - IDX_W;
    localparam int ENT_W = 1 + TAG_W + mem_pkg::LINE_W;

    mem_pkg::cache_state_t           r_state;
    logic                            r_pend;
    logic                            r_sweep_on;
    logic [IDX_W-1:0]                r_sweep_idx;
    logic [LA_W-1:0]                 r_addr;
    logic                            r_we;
    logic [mem_pkg::LINE_W-1:0]      r_wline;
    logic [mem_pkg::LINE_BYTES-1:0]  r_wmask;

    // entry is {valid, tag, line}
    logic [ENT_W-1:0]                mem [CACHE_LINES];
    logic [ENT_W-1:0]                r_ent;

    wire                             w_ent_v;
    wire [TAG_W-1:0]                 w_ent_tag;
    wire [mem_pkg::LINE_W-1:0]       w_ent_data;
    assign {w_ent_v, w_ent_tag, w_ent_data} = r_ent;

    wire w_idle   = (r_state == mem_pkg::C_IDLE);
    wire w_lookup = (r_state == mem_pkg::C_LOOKUP);
    wire w_refill = (r_state == mem_pkg::C_REFILL);
    wire w_write  = (r_state == mem_pkg::C_WRITE);

    // a request seen during the sweep is held in r_pend
    wire             w_go   = w_idle && !r_sweep_on && (i_req || r_pend);
    wire [LA_W-1:0]  w_addr = i_req ? i_addr : r_addr;
    wire             w_hit  = w_ent_v && (w_ent_tag == r_addr[LA_W-1:IDX_W]);

    // sweep, write-through invalidate and refill share one write port
    wire             w_mwe  = r_sweep_on || (w_lookup && r_we) || (w_refill && i_st_ack);
    wire [IDX_W-1:0] w_midx = r_sweep_on ? r_sweep_idx :
                              w_idle     ? w_addr[IDX_W-1:0] : r_addr[IDX_W-1:0];
    wire [ENT_W-1:0] w_mwdata = w_refill ? {1'b1, r_addr[LA_W-1:IDX_W], i_st_rdata} : '0;

    always @(posedge CLK) begin
        if (w_mwe) begin
            mem[w_midx] <= w_mwdata;
        end
        r_ent <= mem[w_midx];
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_state     <= mem_pkg::C_IDLE;
            r_pend      <= 1'b0;
            r_sweep_on  <= 1'b1;
            r_sweep_idx <= '0;
        end else begin
            if (r_sweep_on) begin
                r_sweep_idx <= r_sweep_idx + 1'b1;
                if (r_sweep_idx == IDX_W'(CACHE_LINES - 1)) begin
                    r_sweep_on <= 1'b0;
                end
            end
            if (w_go) begin
                r_pend <= 1'b0;
            end else if (i_req) begin
                r_pend <= 1'b1;
            end
            case (r_state)
                mem_pkg::C_IDLE: begin
                    if (w_go) begin
                        r_state <= mem_pkg::C_LOOKUP;
                    end
                end
                mem_pkg::C_LOOKUP: begin
                    if (r_we) begin
                        r_state <= mem_pkg::C_WRITE;
                    end else if (w_hit) begin
                        r_state <= mem_pkg::C_IDLE;
                    end else begin
                        r_state <= mem_pkg::C_REFILL;
                    end
                end
                default: begin
                    if (i_st_ack) begin
                        r_state <= mem_pkg::C_IDLE;
                    end
                end
            endcase
        end
    end

    // request fields stay put until the store acks
    always_ff @(posedge CLK) begin
        if (w_idle && i_req) begin
            r_addr  <= i_addr;
            r_we    <= i_we;
            r_wline <= i_wline;
            r_wmask <= i_wmask;
        end
    end

    assign o_done     = (w_lookup && !r_we && w_hit) || ((w_refill || w_write) && i_st_ack);
    assign o_rline    = w_lookup ? w_ent_data : i_st_rdata;
    assign o_st_req   = w_refill || w_write;
    assign o_st_we    = w_write;
    assign o_st_line  = r_addr;
    assign o_st_wdata = r_wline;
    assign o_st_mask  = r_wmask;

endmodule

`default_nettype wire

//--- verilog/apb_lane_port.sv
`default_nettype none

module apb_lane_port #(
    parameter int ADDR_W = 16
) (
    input  wire                                  CLK,
    input  wire                                  i_rrst_x,
    input  wire                                  i_psel,
    input  wire                                  i_penable,
    input  wire                                  i_pwrite,
    input  wire  [ADDR_W-1:0]                    i_paddr,
    input  wire  [mem_pkg::WORD_W-1:0]           i_pwdata,
    input  wire  [mem_pkg::CTRL_W-1:0]           i_pctrl,
    input  wire                                  i_done,
    input  wire  [mem_pkg::LINE_W-1:0]           i_rline,
    output logic                                 o_pready,
    output logic [mem_pkg::WORD_W-1:0]           o_prdata,
    output logic                                 o_req,
    output wire                                  o_we,
    output wire  [ADDR_W-mem_pkg::OFFS_W-1:0]    o_addr,
    output wire  [mem_pkg::LINE_W-1:0]           o_wline,
    output wire  [mem_pkg::LINE_BYTES-1:0]       o_wmask,
    output wire  [mem_pkg::CTRL_W-1:0]           o_ctrl
);
    localparam int PAD_W = mem_pkg::LINE_W - mem_pkg::WORD_W;

    logic                          r_busy;
    logic                          r_we;
    logic [ADDR_W-1:0]             r_addr;
    logic [mem_pkg::CTRL_W-1:0]    r_ctrl;
    logic [mem_pkg::WORD_W-1:0]    r_wdata;

    logic [mem_pkg::WORD_W-1:0]    w_word;
    logic [3:0]                    w_bmask;
    logic [mem_pkg::WORD_W-1:0]    w_load;

    // first access-phase cycle of a new transfer
    wire w_start = i_psel && i_penable && !r_busy;

    wire mem_pkg::size_t             w_size = mem_pkg::size_t'(r_ctrl[1:0]);
    wire                             w_uns  = r_ctrl[2];
    wire [mem_pkg::LINE_W-1:0]       w_shift;
    wire [mem_pkg::WORD_W-1:0]       w_lword;

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_busy   <= 1'b0;
            o_req    <= 1'b0;
            o_pready <= 1'b0;
        end else begin
            o_req    <= w_start;
            o_pready <= i_done;
            // busy until the completing edge so the held access phase is not reissued
            if (w_start) begin
                r_busy <= 1'b1;
            end else if (o_pready) begin
                r_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (w_start) begin
            r_we    <= i_pwrite;
            r_addr  <= i_paddr;
            r_ctrl  <= i_pctrl;
            r_wdata <= i_pwdata;
        end
        if (i_done) begin
            o_prdata <= w_load;
        end
    end

    // replicate narrow stores across the word
    always_comb begin
        w_word  = r_wdata;
        w_bmask = 4'b1111;
        case (w_size)
            mem_pkg::SIZE_BYTE: begin
                w_word  = {4{r_wdata[7:0]}};
                w_bmask = 4'b0001 << r_addr[1:0];
            end
            mem_pkg::SIZE_HALF: begin
                w_word  = {2{r_wdata[15:0]}};
                w_bmask = 4'b0011 << {r_addr[1], 1'b0};
            end
            default: ;
        endcase
    end

    // word lane within the line
    assign o_wline = {{PAD_W{1'b0}}, w_word} << {r_addr[mem_pkg::OFFS_W-1:2], 5'b0};
    assign o_wmask = {{(mem_pkg::LINE_BYTES-4){1'b0}}, w_bmask}
                     << {r_addr[mem_pkg::OFFS_W-1:2], 2'b0};

    // load path, addressed byte moved down to bit 0
    assign w_shift = i_rline >> {r_addr[mem_pkg::OFFS_W-1:0], 3'b0};
    assign w_lword = w_shift[mem_pkg::WORD_W-1:0];

    always_comb begin
        case (w_size)
            mem_pkg::SIZE_BYTE: w_load = {{24{w_lword[7] & ~w_uns}}, w_lword[7:0]};
            mem_pkg::SIZE_HALF: w_load = {{16{w_lword[15] & ~w_uns}}, w_lword[15:0]};
            default:            w_load = w_lword;
        endcase
    end

    assign o_we   = r_we;
    assign o_addr = r_addr[ADDR_W-1:mem_pkg::OFFS_W];
    assign o_ctrl = r_ctrl;

endmodule

`default_nettype wire

//--- verilog/apb_data_mem.sv
`default_nettype none

module apb_data_mem #(
    parameter int ADDR_W        = 16,
    parameter int CACHE_LINES   = 8,
    parameter int STORE_LINES   = 64,
    parameter int STORE_LATENCY = 4
) (
    input  wire                          CLK,
    input  wire                          i_rrst_x,
    input  wire                          i_psel,
    input  wire                          i_penable,
    input  wire                          i_pwrite,
    input  wire [ADDR_W-1:0]             i_paddr,
    input  wire [mem_pkg::WORD_W-1:0]    i_pwdata,
    input  wire [mem_pkg::CTRL_W-1:0]    i_pctrl,
    output wire                          o_pready,
    output wire [mem_pkg::WORD_W-1:0]    o_prdata
);
    localparam int LA_W = ADDR_W - mem_pkg::OFFS_W;

    // lane port to cache
    wire                               w_req;
    wire                               w_we;
    wire [LA_W-1:0]                    w_addr;
    wire [mem_pkg::LINE_W-1:0]         w_wline;
    wire [mem_pkg::LINE_BYTES-1:0]     w_wmask;
    wire                               w_done;
    wire [mem_pkg::LINE_W-1:0]         w_rline;

    // cache to store
    wire                               w_st_req;
    wire                               w_st_we;
    wire [LA_W-1:0]                    w_st_line;
    wire [mem_pkg::LINE_W-1:0]         w_st_wdata;
    wire [mem_pkg::LINE_BYTES-1:0]     w_st_mask;
    wire                               w_st_ack;
    wire [mem_pkg::LINE_W-1:0]         w_st_rdata;

    apb_lane_port #(.ADDR_W(ADDR_W)) u_port (
        .CLK(CLK), .i_rrst_x(i_rrst_x),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata), .i_pctrl(i_pctrl),
        .i_done(w_done), .i_rline(w_rline),
        .o_pready(o_pready), .o_prdata(o_prdata),
        .o_req(w_req), .o_we(w_we), .o_addr(w_addr),
        .o_wline(w_wline), .o_wmask(w_wmask),
        // the read cache is size agnostic
        .o_ctrl()
    );

    line_cache #(.ADDR_W(ADDR_W), .CACHE_LINES(CACHE_LINES)) u_cache (
        .CLK(CLK), .i_rrst_x(i_rrst_x),
        .i_req(w_req), .i_we(w_we), .i_addr(w_addr),
        .i_wline(w_wline), .i_wmask(w_wmask),
        .i_st_ack(w_st_ack), .i_st_rdata(w_st_rdata),
        .o_done(w_done), .o_rline(w_rline),
        .o_st_req(w_st_req), .o_st_we(w_st_we), .o_st_line(w_st_line),
        .o_st_wdata(w_st_wdata), .o_st_mask(w_st_mask)
    );

    line_store #(
        .ADDR_W(ADDR_W), .STORE_LINES(STORE_LINES), .STORE_LATENCY(STORE_LATENCY)
    ) u_store (
        .CLK(CLK), .i_rrst_x(i_rrst_x),
        .i_st_req(w_st_req), .i_st_we(w_st_we), .i_st_line(w_st_line),
        .i_st_wdata(w_st_wdata), .i_st_mask(w_st_mask),
        .o_st_ack(w_st_ack), .o_st_rdata(w_st_rdata)
    );

endmodule

`default_nettype wire

//--- tb/apb_data_mem_chk.sv
`default_nettype none

module apb_data_mem_chk #(
    parameter int LA_W = 12
) (
    input  wire                                CLK,
    input  wire                                i_rrst_x,
    input  wire                                i_psel,
    input  wire                                i_penable,
    input  wire                                i_pready,
    input  wire  [1:0]                         i_state,
    input  wire                                i_done,
    input  wire                                i_st_req,
    input  wire                                i_st_ack,
    input  wire                                i_st_we,
    input  wire  [LA_W-1:0]                    i_st_line,
    input  wire  [mem_pkg::LINE_W-1:0]         i_st_wdata,
    input  wire  [mem_pkg::LINE_BYTES-1:0]     i_st_mask
);
    timeunit 1ns;
    timeprecision 1ps;

    // ready only while the host sits in the access phase
    a_pready_access: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        i_pready |-> (i_psel && i_penable))
        else $error("o_pready seen outside the APB access phase");

    // store request held steady while waiting for ack
    a_st_stable: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        (i_st_req && $past(i_st_req) && !$past(i_st_ack)) |->
            (i_st_we == $past(i_st_we) && i_st_line == $past(i_st_line) &&
             i_st_wdata == $past(i_st_wdata) && i_st_mask == $past(i_st_mask)))
        else $error("store request fields changed before ack");

    a_done_src: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        i_done |-> (i_state == mem_pkg::C_LOOKUP || i_st_ack))
        else $error("cache done outside lookup or store ack");

endmodule

bind line_cache apb_data_mem_chk #(.LA_W(ADDR_W - mem_pkg::OFFS_W)) u_chk (
    .CLK(CLK), .i_rrst_x(i_rrst_x),
    .i_psel(1'b0), .i_penable(1'b0), .i_pready(1'b0),
    .i_state(r_state), .i_done(o_done), .i_st_req(o_st_req), .i_st_ack(i_st_ack),
    .i_st_we(o_st_we), .i_st_line(o_st_line), .i_st_wdata(o_st_wdata),
    .i_st_mask(o_st_mask)
);

// only the APB rule is live on the lane port
bind apb_lane_port apb_data_mem_chk u_chk (
    .CLK(CLK), .i_rrst_x(i_rrst_x),
    .i_psel(i_psel), .i_penable(i_penable), .i_pready(o_pready),
    .i_state(mem_pkg::C_IDLE), .i_done(1'b0), .i_st_req(1'b0), .i_st_ack(1'b0),
    .i_st_we(1'b0), .i_st_line('0), .i_st_wdata('0), .i_st_mask('0)
);

`default_nettype wire

//--- tb/tb_apb_data_mem.sv
`default_nettype none

module tb_apb_data_mem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W        = 16;
    localparam int CACHE_LINES   = 8;
    localparam int STORE_LINES   = 64;
    localparam int STORE_LATENCY = 4;
    localparam int RST_CYCLES    = 4;
    localparam int MAX_TESTS     = 64;

    logic                          CLK;
    logic                          i_rrst_x;
    logic                          i_psel;
    logic                          i_penable;
    logic                          i_pwrite;
    logic [ADDR_W-1:0]             i_paddr;
    logic [mem_pkg::WORD_W-1:0]    i_pwdata;
    logic [mem_pkg::CTRL_W-1:0]    i_pctrl;
    wire                           o_pready;
    wire  [mem_pkg::WORD_W-1:0]    o_prdata;

    // one entry per vector line
    logic                          t_write [MAX_TESTS];
    logic [mem_pkg::CTRL_W-1:0]    t_ctrl  [MAX_TESTS];
    logic [ADDR_W-1:0]             t_addr  [MAX_TESTS];
    logic [mem_pkg::WORD_W-1:0]    t_wdata [MAX_TESTS];
    logic [mem_pkg::WORD_W-1:0]    t_exp   [MAX_TESTS];

    int n_tests     = 0;
    int n_checks    = 0;
    int n_errors    = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;

    apb_data_mem #(
        .ADDR_W(ADDR_W), .CACHE_LINES(CACHE_LINES),
        .STORE_LINES(STORE_LINES), .STORE_LATENCY(STORE_LATENCY)
    ) DUT (
        .CLK(CLK), .i_rrst_x(i_rrst_x),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata), .i_pctrl(i_pctrl),
        .o_pready(o_pready), .o_prdata(o_prdata)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles with transfers still pending", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // vector lines are op ctrl addr wdata expect, all hex
    task automatic load_tests();
        int                            fd;
        int                            cnt;
        string                         line;
        logic [3:0]                    op;
        logic [mem_pkg::CTRL_W-1:0]    ctrl;
        logic [ADDR_W-1:0]             addr;
        logic [mem_pkg::WORD_W-1:0]    wdata;
        logic [mem_pkg::WORD_W-1:0]    exp;
        fd = $fopen("tb/mem_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file tb/mem_tests.txt");
            n_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h", op, ctrl, addr, wdata, exp);
                    if (cnt == 5 && n_tests < MAX_TESTS) begin
                        t_write[n_tests] = op[0];
                        t_ctrl[n_tests]  = ctrl;
                        t_addr[n_tests]  = addr;
                        t_wdata[n_tests] = wdata;
                        t_exp[n_tests]   = exp;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one APB transfer, setup then access until ready
    task automatic apb_transfer(
        input  logic                          wr,
        input  logic [mem_pkg::CTRL_W-1:0]    ctrl,
        input  logic [ADDR_W-1:0]             addr,
        input  logic [mem_pkg::WORD_W-1:0]    wdata,
        output logic [mem_pkg::WORD_W-1:0]    rdata
    );
        @(posedge CLK);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= wr;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        i_pctrl   <= ctrl;
        @(posedge CLK);
        i_penable <= 1'b1;
        // ready is registered, look at it mid cycle
        @(negedge CLK);
        while (!o_pready) begin
            @(negedge CLK);
        end
        rdata = o_prdata;
        @(posedge CLK);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    initial begin
        logic [mem_pkg::WORD_W-1:0] rdata;
        void'($urandom(32'h482e));
        i_rrst_x  = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        i_pctrl   = '0;
        load_tests();
        if (n_tests == 0) begin
            $display("no test vectors were loaded");
            n_errors++;
        end
        // reset sweep of the cache adds CACHE_LINES cycles once
        cycle_limit = n_tests * (10 + STORE_LATENCY + 3) + RST_CYCLES + CACHE_LINES;
        repeat (RST_CYCLES) @(posedge CLK);
        i_rrst_x <= 1'b1;
        for (int k = 0; k < n_tests; k++) begin
            repeat ($urandom_range(3, 0)) @(posedge CLK);
            apb_transfer(t_write[k], t_ctrl[k], t_addr[k], t_wdata[k], rdata);
            if (!t_write[k]) begin
                n_checks++;
                if (rdata !== t_exp[k]) begin
                    $display("error: o_prdata addr %h ctrl %h got %h expected %h",
                             t_addr[k], t_ctrl[k], rdata, t_exp[k]);
                    n_errors++;
                end
            end
        end
        $display("transfers %0d, read checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/mem_tests.txt
# op ctrl addr wdata expect, all hex; op 1 write, 0 read, expect ignored on writes
# ctrl bit 2 unsigned, bits 1..0 size (0 byte, 1 half, 2 word)
1 2 0010 12345678 00000000
0 2 0010 00000000 12345678
1 2 001c cafef00d 00000000
0 2 001c 00000000 cafef00d
# narrow writes merge into a zeroed word
1 0 0021 000000ab 00000000
1 1 0022 0000beef 00000000
0 2 0020 00000000 beefab00
0 2 0024 00000000 00000000
# sign and zero extension, top bit set at every offset
1 2 0030 f0a08180 00000000
0 0 0030 00000000 ffffff80
0 0 0031 00000000 ffffff81
0 0 0032 00000000 ffffffa0
0 0 0033 00000000 fffffff0
0 4 0031 00000000 00000081
0 4 0033 00000000 000000f0
0 1 0032 00000000 fffff0a0
0 5 0030 00000000 00008180
# cached line dropped by a write, then same index with two tags
0 2 0044 00000000 00000000
1 2 0044 11223344 00000000
0 2 0044 00000000 11223344
1 2 00c8 a5a5c3c3 00000000
0 2 0044 00000000 11223344
0 2 00c8 00000000 a5a5c3c3
0 2 0044 00000000 11223344
0 2 00c8 00000000 a5a5c3c3
0 2 0380 00000000 00000000
0 1 01f6 00000000 00000000

//--- project.f
verilog/mem_pkg.sv
verilog/line_store.sv
verilog/line_cache.sv
verilog/apb_lane_port.sv
verilog/apb_data_mem.sv
tb/apb_data_mem_chk.sv
tb/tb_apb_data_mem.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run from the project root, then scan the log
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal -f project.f \
    --top-module tb_apb_data_mem -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && ! grep -q "TEST RESULT: FAIL" sim.log \
    && cat sim.log \
    || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
